// ==== Bender.yml ====
package:
  name: oscillator

sources:
  - source/osc_apb_pkg.sv
  - source/osc_wave_pkg.sv
  - source/oscillator_apb3_slave.sv
  - source/oscillator_core.sv
  - source/oscillator_top.sv
  - target: test
    files:
      - test/oscillator_assertions.sv
      - test/oscillator_tb.sv

// ==== all.f ====
source/osc_apb_pkg.sv
source/osc_wave_pkg.sv
source/oscillator_apb3_slave.sv
source/oscillator_core.sv
source/oscillator_top.sv
test/oscillator_assertions.sv
test/oscillator_tb.sv

// ==== source/osc_apb_pkg.sv ====
/*
 * register map of the oscillator APB3 block
 *   osc_reg_offset_e  byte offsets of the configuration registers
 *   OSC_N_REGS        number of registers in the block
 */
package osc_apb_pkg;

  //////////////////////////////////////////////////
  // register offsets
  //////////////////////////////////////////////////

  // byte offsets from the block base, one 32-bit word per register
  typedef enum logic [3:0] {
    OSC_REG_WAVE_E   = 4'h0,  // waveform select
    OSC_REG_FREQ_E   = 4'h4,  // phase step per clock
    OSC_REG_DUTY_E   = 4'h8,  // square threshold on the phase
    OSC_REG_ENABLE_E = 4'hC   // bit 0 runs the accumulator
  } osc_reg_offset_e;

  //////////////////////////////////////////////////
  // block size
  //////////////////////////////////////////////////

  localparam int OSC_N_REGS = 4;  // words decoded inside the block

endpackage

// ==== source/osc_wave_pkg.sv ====
/*
 * waveform definitions of the oscillator
 *   osc_waveform_t    output selection codes
 *   sample extremes   largest positive and negative square levels
 */
package osc_wave_pkg;

  localparam int OSC_WAVE_SEL_WIDTH = 2;  // bits of the select field

  typedef enum logic [OSC_WAVE_SEL_WIDTH-1:0] {
    OSC_SQUARE_E   = 2'd0,
    OSC_TRIANGLE_E = 2'd1,
    OSC_SAW_E      = 2'd2,
    OSC_MUTE_E     = 2'd3   // output held at zero
  } osc_waveform_t;

  // largest positive value of a signed sample of the given width
  function automatic int osc_sample_max(input int width);
    return (1 << (width - 1)) - 1;
  endfunction

  // symmetric negative level, one above the two's complement minimum
  function automatic int osc_sample_neg_max(input int width);
    return -osc_sample_max(width);
  endfunction

endpackage

// ==== source/oscillator_apb3_slave.sv ====
/*
 * APB3 register slave of the oscillator
 *   address decode against the block base and the offset map
 *   waveform select, frequency step, duty cycle and enable registers
 */
module oscillator_apb3_slave #(
  parameter int N_BITS_P         = 16,
  parameter int APB_ADDR_WIDTH_P = 12,
  parameter int APB_DATA_WIDTH_P = 32,
  parameter int APB_BASE_ADDR_P  = 'h100
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        apb3_psel,
  input  logic                        apb3_penable,
  input  logic                        apb3_pwrite,
  input  logic [APB_ADDR_WIDTH_P-1:0] apb3_paddr,
  input  logic [APB_DATA_WIDTH_P-1:0] apb3_pwdata,
  output logic                        apb3_pready,
  output logic [APB_DATA_WIDTH_P-1:0] apb3_prdata,
  output osc_wave_pkg::osc_waveform_t wave_select,
  output logic [N_BITS_P-1:0]         frequency,
  output logic [N_BITS_P-1:0]         duty_cycle,
  output logic                        enable
);

  import osc_apb_pkg::*;
  import osc_wave_pkg::*;

  localparam logic [APB_ADDR_WIDTH_P-1:0] BASE_ADDR_C  = APB_ADDR_WIDTH_P'(APB_BASE_ADDR_P);
  localparam logic [APB_ADDR_WIDTH_P-1:0] BLOCK_SIZE_C = APB_ADDR_WIDTH_P'(4 * OSC_N_REGS);

  logic [APB_ADDR_WIDTH_P-1:0] reg_offset;
  logic                        in_block;
  osc_reg_offset_e             reg_sel;
  logic                        hit_wave;
  logic                        hit_freq;
  logic                        hit_duty;
  logic                        hit_enable;
  logic [APB_DATA_WIDTH_P-1:0] read_data;
  logic                        setup_read;
  logic                        access_write;

  assign apb3_pready = 1'b1;  // zero wait states

  //////////////////////////////////////////////////
  // address decode and read-back mux
  //////////////////////////////////////////////////

  assign reg_offset = apb3_paddr - BASE_ADDR_C;
  assign in_block   = (apb3_paddr >= BASE_ADDR_C) && (reg_offset < BLOCK_SIZE_C);
  assign reg_sel    = osc_reg_offset_e'(reg_offset[$bits(osc_reg_offset_e)-1:0]);

  always_comb begin
    hit_wave   = 1'b0;
    hit_freq   = 1'b0;
    hit_duty   = 1'b0;
    hit_enable = 1'b0;
    read_data  = '0;  // unused bits and misses read as zero
    if (in_block) begin
      case (reg_sel)
        OSC_REG_WAVE_E: begin
          hit_wave  = 1'b1;
          read_data = APB_DATA_WIDTH_P'(wave_select);
        end
        OSC_REG_FREQ_E: begin
          hit_freq  = 1'b1;
          read_data = APB_DATA_WIDTH_P'(frequency);
        end
        OSC_REG_DUTY_E: begin
          hit_duty  = 1'b1;
          read_data = APB_DATA_WIDTH_P'(duty_cycle);
        end
        OSC_REG_ENABLE_E: begin
          hit_enable = 1'b1;
          read_data  = APB_DATA_WIDTH_P'(enable);
        end
        default: begin
        end  // unaligned offset inside the block
      endcase
    end
  end

  //////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////

  assign access_write = apb3_psel && apb3_penable && apb3_pwrite;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wave_select <= OSC_SQUARE_E;
      frequency   <= '0;
      duty_cycle  <= '0;
      enable      <= 1'b0;
    end else if (access_write) begin
      if (hit_wave) begin
        wave_select <= osc_waveform_t'(apb3_pwdata[OSC_WAVE_SEL_WIDTH-1:0]);
      end
      if (hit_freq) begin
        frequency <= apb3_pwdata[N_BITS_P-1:0];  // phase step, no scaling
      end
      if (hit_duty) begin
        duty_cycle <= apb3_pwdata[N_BITS_P-1:0];
      end
      if (hit_enable) begin
        enable <= apb3_pwdata[0];
      end
    end
  end

  // read data loaded in the setup cycle, valid through the access cycle
  assign setup_read = apb3_psel && !apb3_penable && !apb3_pwrite;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      apb3_prdata <= '0;
    end else begin
      apb3_prdata <= setup_read ? read_data : '0;  // zero outside a read access
    end
  end

endmodule

// ==== source/oscillator_core.sv ====
/*
 * oscillator core
 *   phase accumulator with enable and clear
 *   registered square, triangle and sawtooth samples
 */
module oscillator_core #(
  parameter int N_BITS_P     = 16,
  parameter int WAVE_WIDTH_P = 8
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [N_BITS_P-1:0]            frequency,
  input  logic [N_BITS_P-1:0]            duty_cycle,
  input  logic                           enable,
  output logic signed [WAVE_WIDTH_P-1:0] wave_square,
  output logic signed [WAVE_WIDTH_P-1:0] wave_triangle,
  output logic signed [WAVE_WIDTH_P-1:0] wave_saw
);

  import osc_wave_pkg::*;

  // square levels, symmetric around zero
  localparam logic signed [WAVE_WIDTH_P-1:0] WAVE_MAX_C =
    WAVE_WIDTH_P'(osc_sample_max(WAVE_WIDTH_P));
  localparam logic signed [WAVE_WIDTH_P-1:0] WAVE_NEG_MAX_C =
    WAVE_WIDTH_P'(osc_sample_neg_max(WAVE_WIDTH_P));

  // xor mask turning an offset binary value into two's complement
  localparam logic [WAVE_WIDTH_P-1:0] SIGN_FLIP_C = {1'b1, {(WAVE_WIDTH_P-1){1'b0}}};

  logic [N_BITS_P-1:0]            phase;
  logic [WAVE_WIDTH_P-1:0]        saw_bits;
  logic [WAVE_WIDTH_P-1:0]        tri_bits;
  logic [WAVE_WIDTH_P-1:0]        tri_folded;
  logic signed [WAVE_WIDTH_P-1:0] square_next;
  logic signed [WAVE_WIDTH_P-1:0] triangle_next;
  logic signed [WAVE_WIDTH_P-1:0] saw_next;

  //////////////////////////////////////////////////
  // phase accumulator
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= '0;
    end else if (enable) begin
      phase <= phase + frequency;  // wraps modulo 2**N_BITS_P
    end else begin
      phase <= '0;  // stopped oscillator restarts at phase zero
    end
  end

  //////////////////////////////////////////////////
  // waveform generation from the phase
  //////////////////////////////////////////////////

  // square compares the whole phase against the duty threshold
  assign square_next = (phase < duty_cycle) ? WAVE_MAX_C : WAVE_NEG_MAX_C;

  // saw is the top of the phase, re-centred around zero
  assign saw_bits = phase[N_BITS_P-1 -: WAVE_WIDTH_P];
  assign saw_next = saw_bits ^ SIGN_FLIP_C;

  // triangle folds the second half of the period back down
  assign tri_bits      = phase[N_BITS_P-2 -: WAVE_WIDTH_P];
  assign tri_folded    = phase[N_BITS_P-1] ? ~tri_bits : tri_bits;  // falling half
  assign triangle_next = tri_folded ^ SIGN_FLIP_C;

  //////////////////////////////////////////////////
  // sample registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wave_square   <= '0;
      wave_triangle <= '0;
      wave_saw      <= '0;
    end else begin
      wave_square   <= square_next;    // one cycle behind the phase
      wave_triangle <= triangle_next;
      wave_saw      <= saw_next;
    end
  end

endmodule

// ==== source/oscillator_top.sv ====
/*
 * oscillator top level
 *   APB3 configuration slave and oscillator core
 *   registered waveform output selection
 */
module oscillator_top #(
  parameter int N_BITS_P         = 16,
  parameter int WAVE_WIDTH_P     = 8,
  parameter int APB_ADDR_WIDTH_P = 12,
  parameter int APB_DATA_WIDTH_P = 32,
  parameter int APB_BASE_ADDR_P  = 'h100
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           apb3_psel,
  input  logic                           apb3_penable,
  input  logic                           apb3_pwrite,
  input  logic [APB_ADDR_WIDTH_P-1:0]    apb3_paddr,
  input  logic [APB_DATA_WIDTH_P-1:0]    apb3_pwdata,
  output logic                           apb3_pready,
  output logic [APB_DATA_WIDTH_P-1:0]    apb3_prdata,
  output logic signed [WAVE_WIDTH_P-1:0] waveform
);

  import osc_wave_pkg::*;

  osc_waveform_t                  wave_select;
  logic [N_BITS_P-1:0]            frequency;
  logic [N_BITS_P-1:0]            duty_cycle;
  logic                           enable;
  logic signed [WAVE_WIDTH_P-1:0] wave_square;
  logic signed [WAVE_WIDTH_P-1:0] wave_triangle;
  logic signed [WAVE_WIDTH_P-1:0] wave_saw;

  //////////////////////////////////////////////////
  // output selection
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      waveform <= '0;
    end else begin
      case (wave_select)
        OSC_SQUARE_E:   waveform <= wave_square;
        OSC_TRIANGLE_E: waveform <= wave_triangle;
        OSC_SAW_E:      waveform <= wave_saw;
        OSC_MUTE_E:     waveform <= '0;  // silence
      endcase
    end
  end

  oscillator_apb3_slave #(
    .N_BITS_P         (N_BITS_P),
    .APB_ADDR_WIDTH_P (APB_ADDR_WIDTH_P),
    .APB_DATA_WIDTH_P (APB_DATA_WIDTH_P),
    .APB_BASE_ADDR_P  (APB_BASE_ADDR_P)
  ) oscillator_apb3_slave_i0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .apb3_psel    (apb3_psel),
    .apb3_penable (apb3_penable),
    .apb3_pwrite  (apb3_pwrite),
    .apb3_paddr   (apb3_paddr),
    .apb3_pwdata  (apb3_pwdata),
    .apb3_pready  (apb3_pready),
    .apb3_prdata  (apb3_prdata),
    .wave_select  (wave_select),
    .frequency    (frequency),
    .duty_cycle   (duty_cycle),
    .enable       (enable)
  );

  oscillator_core #(
    .N_BITS_P     (N_BITS_P),
    .WAVE_WIDTH_P (WAVE_WIDTH_P)
  ) oscillator_core_i0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .frequency     (frequency),
    .duty_cycle    (duty_cycle),
    .enable        (enable),
    .wave_square   (wave_square),
    .wave_triangle (wave_triangle),
    .wave_saw      (wave_saw)
  );

endmodule

// ==== test/oscillator_assertions.sv ====
/*
 * concurrent checks on the oscillator top level
 *   APB3 ready and read data rules
 *   square and mute output levels
 */
module oscillator_assertions #(
  parameter int WAVE_WIDTH_P     = 8,
  parameter int APB_DATA_WIDTH_P = 32
) (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           apb3_psel,
  input logic                           apb3_penable,
  input logic                           apb3_pwrite,
  input logic                           apb3_pready,
  input logic [APB_DATA_WIDTH_P-1:0]    apb3_prdata,
  input osc_wave_pkg::osc_waveform_t    wave_select,
  input logic signed [WAVE_WIDTH_P-1:0] waveform
);

  timeunit 1ns;
  timeprecision 1ps;

  import osc_wave_pkg::*;

  localparam logic signed [WAVE_WIDTH_P-1:0] LEVEL_MAX_C = (1 << (WAVE_WIDTH_P - 1)) - 1;

  int unsigned failure_count = 0;  // failed checks so far
  logic        read_access;

  assign read_access = apb3_psel && apb3_penable && !apb3_pwrite;

  //////////////////////////////////////////////////
  // APB3 rules
  //////////////////////////////////////////////////

  pready_high_a: assert property (@(posedge clk) rst_n |-> apb3_pready)
    else begin
      $error("pready low while out of reset");
      failure_count++;
    end

  prdata_idle_zero_a: assert property (@(posedge clk) disable iff (!rst_n)
    !read_access |-> apb3_prdata == '0)
    else begin
      $error("prdata not zero outside a read access");
      failure_count++;
    end

  //////////////////////////////////////////////////
  // output levels
  //////////////////////////////////////////////////

  // square samples are valid one edge after reset ends
  square_level_a: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) && wave_select == OSC_SQUARE_E && $stable(wave_select)
    |=> waveform == LEVEL_MAX_C || waveform == -LEVEL_MAX_C)
    else begin
      $error("square output is not at a full scale level");
      failure_count++;
    end

  mute_zero_a: assert property (@(posedge clk) disable iff (!rst_n)
    wave_select == OSC_MUTE_E && $stable(wave_select) |=> waveform == '0)
    else begin
      $error("muted output is not zero");
      failure_count++;
    end

endmodule

bind oscillator_top oscillator_assertions #(
  .WAVE_WIDTH_P     (WAVE_WIDTH_P),
  .APB_DATA_WIDTH_P (APB_DATA_WIDTH_P)
) oscillator_assertions_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .apb3_psel    (apb3_psel),
  .apb3_penable (apb3_penable),
  .apb3_pwrite  (apb3_pwrite),
  .apb3_pready  (apb3_pready),
  .apb3_prdata  (apb3_prdata),
  .wave_select  (wave_select),
  .waveform     (waveform)
);

// ==== test/oscillator_tb.sv ====
/*
 * testbench of the oscillator top level
 *   clock, reset and APB3 access tasks
 *   reference model of the phase accumulator and the sample pipeline
 *   per-cycle waveform compare and cycle timeout
 */
module oscillator_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import osc_apb_pkg::*;
  import osc_wave_pkg::*;

  localparam int N_BITS_C         = 16;
  localparam int WAVE_WIDTH_C     = 8;
  localparam int BASE_ADDR_C      = 'h100;
  localparam int PHASE_MOD_C      = 1 << N_BITS_C;
  localparam int HALF_PERIOD_C    = 20;
  localparam int DRIVE_DELAY_C    = 2;
  localparam int TIMEOUT_CYCLES_C = 4000;  // tests need about 2500 cycles

  logic                           clk;
  logic                           rst_n;
  logic                           apb3_psel;
  logic                           apb3_penable;
  logic                           apb3_pwrite;
  logic [11:0]                    apb3_paddr;
  logic [31:0]                    apb3_pwdata;
  logic                           apb3_pready;
  logic [31:0]                    apb3_prdata;
  logic signed [WAVE_WIDTH_C-1:0] waveform;

  int model_select      = 0;  // configuration as seen on the bus
  int model_freq        = 0;
  int model_duty        = 0;
  int model_enable      = 0;
  int model_phase       = 0;
  int stage_phase       = 0;  // sample stage of the core
  int stage_duty        = 0;
  bit stage_valid       = 1'b0;
  int expected_waveform = 0;
  int cycle_count       = 0;

  oscillator_top dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .apb3_psel    (apb3_psel),
    .apb3_penable (apb3_penable),
    .apb3_pwrite  (apb3_pwrite),
    .apb3_paddr   (apb3_paddr),
    .apb3_pwdata  (apb3_pwdata),
    .apb3_pready  (apb3_pready),
    .apb3_prdata  (apb3_prdata),
    .waveform     (waveform)
  );

  always #HALF_PERIOD_C clk = ~clk;

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic int expected_sample(input int phase, input int duty, input int select);
    int half_scale;
    int fold;
    int result;
    half_scale = 1 << (WAVE_WIDTH_C - 1);
    result     = 0;  // mute
    case (select)
      OSC_SQUARE_E: result = (phase < duty) ? half_scale - 1 : 1 - half_scale;
      OSC_SAW_E:    result = (phase >> (N_BITS_C - WAVE_WIDTH_C)) - half_scale;
      OSC_TRIANGLE_E: begin
        fold = (phase >> (N_BITS_C - 1 - WAVE_WIDTH_C)) % (2 * half_scale);
        if (phase >= PHASE_MOD_C / 2) begin
          fold = 2 * half_scale - 1 - fold;  // falling half of the period
        end
        result = fold - half_scale;
      end
      default: begin
      end
    endcase
    return result;
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      model_select      = 0;
      model_freq        = 0;
      model_duty        = 0;
      model_enable      = 0;
      model_phase       = 0;
      stage_valid       = 1'b0;
      expected_waveform = 0;
    end else begin
      // oldest stage first so each stage uses last cycle's values
      expected_waveform = stage_valid ?
        expected_sample(stage_phase, stage_duty, model_select) : 0;
      stage_phase = model_phase;
      stage_duty  = model_duty;
      stage_valid = 1'b1;
      model_phase = model_enable ? (model_phase + model_freq) % PHASE_MOD_C : 0;
      if (apb3_psel && apb3_penable && apb3_pwrite && apb3_paddr >= BASE_ADDR_C &&
          apb3_paddr < BASE_ADDR_C + 4 * OSC_N_REGS) begin
        case (int'(apb3_paddr) - BASE_ADDR_C)
          OSC_REG_WAVE_E:   model_select = apb3_pwdata % 4;
          OSC_REG_FREQ_E:   model_freq   = apb3_pwdata % PHASE_MOD_C;
          OSC_REG_DUTY_E:   model_duty   = apb3_pwdata % PHASE_MOD_C;
          OSC_REG_ENABLE_E: model_enable = apb3_pwdata % 2;
          default: begin
          end
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // compare and timeout
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic signed [63:0] actual,
                             input logic signed [63:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
      $display("** FAIL **");
      $fatal(1, "value mismatch");
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      check_value("waveform", waveform, expected_waveform);  // sampled mid-cycle where stable
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES_C) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES_C);
      $display("** FAIL **");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////
  // APB3 access tasks
  //////////////////////////////////////////////////

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    @(posedge clk);
    #DRIVE_DELAY_C;
    apb3_psel   = 1'b1;  // setup cycle
    apb3_pwrite = 1'b1;
    apb3_paddr  = addr;
    apb3_pwdata = data;
    @(posedge clk);
    #DRIVE_DELAY_C;
    apb3_penable = 1'b1;
    @(negedge clk);
    while (!apb3_pready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #DRIVE_DELAY_C;
    apb3_psel    = 1'b0;
    apb3_penable = 1'b0;
    apb3_pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
    @(posedge clk);
    #DRIVE_DELAY_C;
    apb3_psel   = 1'b1;
    apb3_pwrite = 1'b0;
    apb3_paddr  = addr;
    @(posedge clk);
    #DRIVE_DELAY_C;
    apb3_penable = 1'b1;
    @(negedge clk);
    while (!apb3_pready) begin
      @(negedge clk);
    end
    data = apb3_prdata;
    @(posedge clk);
    #DRIVE_DELAY_C;
    apb3_psel    = 1'b0;
    apb3_penable = 1'b0;
  endtask

  task automatic read_expect(input logic [11:0] addr, input logic [31:0] expected);
    logic [31:0] data;
    apb_read(addr, data);
    check_value("prdata", data, expected);
  endtask

  task automatic run_cycles(input int count);
    repeat (count) @(posedge clk);
  endtask

  // small random step and then a step close to full scale that wraps every cycle
  task automatic sweep_steps(input int select);
    apb_write(BASE_ADDR_C + OSC_REG_WAVE_E, select);
    apb_write(BASE_ADDR_C + OSC_REG_FREQ_E, ($urandom() % 2048) + 1);
    run_cycles(300);
    apb_write(BASE_ADDR_C + OSC_REG_FREQ_E, PHASE_MOD_C - 1 - ($urandom() % 256));
    run_cycles(300);
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(39));
    clk          = 1'b0;
    rst_n        = 1'b0;
    apb3_psel    = 1'b0;
    apb3_penable = 1'b0;
    apb3_pwrite  = 1'b0;
    apb3_paddr   = '0;
    apb3_pwdata  = '0;
    repeat (3) @(posedge clk);
    #DRIVE_DELAY_C rst_n = 1'b1;

    // reset values
    @(negedge clk);
    check_value("waveform", waveform, 0);
    for (int off = 0; off < 4 * OSC_N_REGS; off += 4) begin
      read_expect(BASE_ADDR_C + off, 0);
    end

    // register access with truncation to the field widths
    apb_write(BASE_ADDR_C + OSC_REG_WAVE_E, 32'hFFFF_FFFE);
    apb_write(BASE_ADDR_C + OSC_REG_FREQ_E, 32'hDEAD_BEEF);
    apb_write(BASE_ADDR_C + OSC_REG_DUTY_E, 32'h1234_5678);
    apb_write(BASE_ADDR_C + OSC_REG_ENABLE_E, 32'hFFFF_FFFF);
    apb_write(BASE_ADDR_C - 4, 32'h0000_0000);   // below the block
    apb_write(BASE_ADDR_C + 16, 32'h0000_0003);  // above the block
    apb_write(BASE_ADDR_C + 2, 32'h0000_FFFF);   // unmapped offsets
    apb_write(BASE_ADDR_C + 10, 32'h0000_FFFF);
    read_expect(BASE_ADDR_C + OSC_REG_WAVE_E, 2);
    read_expect(BASE_ADDR_C + OSC_REG_FREQ_E, 16'hBEEF);
    read_expect(BASE_ADDR_C + OSC_REG_DUTY_E, 16'h5678);
    read_expect(BASE_ADDR_C + OSC_REG_ENABLE_E, 1);
    read_expect(BASE_ADDR_C - 4, 0);
    read_expect(BASE_ADDR_C + 16, 0);
    read_expect(0, 0);

    // square with three duty values
    apb_write(BASE_ADDR_C + OSC_REG_WAVE_E, OSC_SQUARE_E);
    apb_write(BASE_ADDR_C + OSC_REG_FREQ_E, ($urandom() % 2048) + 1);
    apb_write(BASE_ADDR_C + OSC_REG_DUTY_E, 0);
    run_cycles(300);
    apb_write(BASE_ADDR_C + OSC_REG_DUTY_E, PHASE_MOD_C / 2);
    run_cycles(300);
    apb_write(BASE_ADDR_C + OSC_REG_DUTY_E, $urandom() % PHASE_MOD_C);
    run_cycles(300);

    // triangle and saw
    sweep_steps(OSC_TRIANGLE_E);
    sweep_steps(OSC_SAW_E);

    // mute and then stop and restart the accumulator
    apb_write(BASE_ADDR_C + OSC_REG_WAVE_E, OSC_MUTE_E);
    run_cycles(50);
    @(negedge clk);
    check_value("waveform", waveform, 0);
    apb_write(BASE_ADDR_C + OSC_REG_WAVE_E, OSC_SAW_E);
    apb_write(BASE_ADDR_C + OSC_REG_ENABLE_E, 0);
    run_cycles(20);
    @(negedge clk);
    check_value("waveform", waveform, -(1 << (WAVE_WIDTH_C - 1)));  // saw at phase zero
    apb_write(BASE_ADDR_C + OSC_REG_ENABLE_E, 1);
    run_cycles(200);

    if (dut_i.oscillator_assertions_i.failure_count == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("%0d assertion failures", dut_i.oscillator_assertions_i.failure_count);
      $display("** FAIL **");
      $fatal(1, "assertion failures");
    end
  end

endmodule
